/* common/vsld_pkg.sv */
package vsld_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  // Architectural vector registers
  localparam int unsigned NrVregs = 8;
  // Bytes in one register-file word
  localparam int unsigned VrfWordBytes = 4;
  // Words that make up one vector register
  localparam int unsigned NrWordsPerVector = 4;
  // Bytes in one vector register
  localparam int unsigned MaxVlBytes = VrfWordBytes * NrWordsPerVector;

  ////////////////////
  // Widths
  ////////////////////

  // One register-file word and its byte enables
  typedef logic [8*VrfWordBytes-1:0] vreg_data_t;
  typedef logic [VrfWordBytes-1:0] vreg_be_t;

  // Register number in the upper bits, word index in the lower bits
  typedef logic [$clog2(NrVregs*NrWordsPerVector)-1:0] vreg_addr_t;
  typedef logic [$clog2(NrVregs)-1:0] vreg_idx_t;

  // Byte count or byte position, wide enough to hold MaxVlBytes itself
  typedef logic [$clog2(MaxVlBytes):0] vlen_t;

  // Scalar operand
  typedef logic [31:0] elem_t;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [1:0] {
    SLIDE_UP,
    SLIDE_DOWN,
    SLIDE1_UP,
    SLIDE1_DOWN
  } sld_op_e;

  // Encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  ////////////////////
  // Transfers
  ////////////////////

  // Slide request, vl counted in elements
  typedef struct packed {
    sld_op_e   op;
    vsew_e     vsew;
    vlen_t     vl;
    vreg_idx_t vd;
    vreg_idx_t vs2;
    elem_t     rs1;
  } sld_req_t;

  // Completion of one instruction
  typedef struct packed {
    vreg_idx_t vd;
  } sld_rsp_t;

  // One word write toward the register file
  typedef struct packed {
    vreg_addr_t waddr;
    vreg_data_t wdata;
    vreg_be_t   wbe;
  } vrf_wreq_t;

endpackage

/* hdl/spill_register.sv */
`timescale 1ns/1ps

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot a takes new data, slot b holds the older entry when the output stalls
  T     a_data_q;
  T     b_data_q;
  logic a_full_q;
  logic b_full_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  assign a_fill  = valid_i && ready_o;
  // Slot a moves on whenever slot b is free
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Ready only looks at local state, so the ready path is cut here
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  // Oldest entry first
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

/* vsldu/vsldu_byte_shifter.sv */
`timescale 1ns/1ps

module vsldu_byte_shifter import vsld_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       step_i,
  input  logic       clear_i,
  input  logic       slide_up_i,
  input  logic [1:0] offset_i,
  input  vreg_data_t rdata_i,
  input  logic       zero_fill_i,
  input  logic       insert_up_i,
  input  logic       insert_down_i,
  input  vlen_t      insert_pos_i,
  input  elem_t      scalar_i,
  output vreg_data_t data_o
);

  localparam int unsigned ByteIdxW = $clog2(VrfWordBytes);

  // Bytes that belong to the next destination word
  vreg_data_t overflow_q;
  vreg_data_t overflow_next;

  vreg_data_t data_in;
  vreg_data_t data_high;
  vreg_data_t data_low;
  vreg_data_t data_shift;
  vreg_data_t data_word;

  always_comb begin : proc_shift
    // Slide up is done as a slide down on the byte-reversed word
    for (int b = 0; b < VrfWordBytes; b++) begin
      data_in[b*8 +: 8] = slide_up_i ? rdata_i[(VrfWordBytes-1-b)*8 +: 8] : rdata_i[b*8 +: 8];
    end
    if (zero_fill_i) begin
      data_in = '0;
    end

    // Split into bytes staying low and bytes wrapping to the top
    data_high = '0;
    data_low  = '0;
    for (int b = 0; b < VrfWordBytes; b++) begin
      if (b >= offset_i) begin
        data_high[(b - offset_i)*8 +: 8] = data_in[b*8 +: 8];
      end else begin
        data_low[(b + VrfWordBytes - offset_i)*8 +: 8] = data_in[b*8 +: 8];
      end
    end

    if (slide_up_i) begin
      overflow_next = data_low;
      data_shift    = data_high | overflow_q;
    end else begin
      overflow_next = data_high;
      data_shift    = data_low | overflow_q;
    end

    // Undo the reversal
    for (int b = 0; b < VrfWordBytes; b++) begin
      data_word[b*8 +: 8] = slide_up_i ? data_shift[(VrfWordBytes-1-b)*8 +: 8]
                                       : data_shift[b*8 +: 8];
    end

    // Scalar comes in already masked to one element
    if (insert_up_i) begin
      data_word = data_word | scalar_i;
    end

    // Last element of a slide-one down
    if (insert_down_i) begin
      for (int b = 0; b < VrfWordBytes; b++) begin
        if (b >= insert_pos_i[ByteIdxW-1:0]) begin
          data_word[b*8 +: 8] = scalar_i[(b - insert_pos_i[ByteIdxW-1:0])*8 +: 8];
        end
      end
    end
  end

  assign data_o = data_word;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      overflow_q <= '0;
    end else if (clear_i) begin
      overflow_q <= '0;
    end else if (step_i) begin
      overflow_q <= overflow_next;
    end
  end

endmodule

/* vsldu/vsldu.sv */
`timescale 1ns/1ps

module vsldu import vsld_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  sld_req_t   req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output logic       rsp_valid_o,
  output sld_rsp_t   rsp_o,
  output logic       vrf_re_o,
  output vreg_addr_t vrf_raddr_o,
  input  vreg_data_t vrf_rdata_i,
  input  logic       vrf_rvalid_i,
  output logic       vrf_we_o,
  output vrf_wreq_t  vrf_wreq_o,
  input  logic       vrf_wvalid_i
);

  localparam int unsigned ByteIdxW = $clog2(VrfWordBytes);
  localparam int unsigned WordIdxW = $clog2(NrWordsPerVector);
  localparam int unsigned SrcW     = WordIdxW + 3;

  ////////////////////
  // Operation queue
  ////////////////////

  sld_req_t req_d;
  sld_req_t queue_req;
  logic     queue_valid;
  logic     queue_ready;

  // vl and slide amount in bytes, amount saturated at one full register
  always_comb begin : proc_convert
    req_d    = req_i;
    req_d.vl = vlen_t'(req_i.vl << req_i.vsew);
    if (req_i.op inside {SLIDE1_UP, SLIDE1_DOWN}) begin
      unique case (req_i.vsew)
        EW_8:    req_d.rs1 = elem_t'(req_i.rs1[7:0]);
        EW_16:   req_d.rs1 = elem_t'(req_i.rs1[15:0]);
        default: req_d.rs1 = req_i.rs1;
      endcase
    end else if (req_i.rs1 >= elem_t'(MaxVlBytes >> req_i.vsew)) begin
      req_d.rs1 = elem_t'(MaxVlBytes);
    end else begin
      req_d.rs1 = req_i.rs1 << req_i.vsew;
    end
  end

  spill_register #(
    .T(sld_req_t)
  ) i_op_queue (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  (req_d),
    .valid_o (queue_valid),
    .ready_i (queue_ready),
    .data_o  (queue_req)
  );

  ////////////////////
  // Active operation
  ////////////////////

  sld_req_t   req_q;
  logic       active_q;
  vlen_t      slide_amount_q;
  logic       prefetch_q;
  vlen_t      counter_q;
  logic [1:0] pending_q;

  vlen_t amt_start;
  logic  op_empty;
  logic  start;
  logic  slide_up;
  logic  rd_ok;
  logic  push;
  logic  pop;
  logic  wreq_ready;

  assign amt_start = (queue_req.op inside {SLIDE1_UP, SLIDE1_DOWN}) ?
                     vlen_t'(1) << queue_req.vsew : vlen_t'(queue_req.rs1);
  // Nothing to write, answer straight away
  assign op_empty  = (queue_req.vl == '0) ||
                     (queue_req.op == SLIDE_UP && amt_start >= queue_req.vl);
  // No writes of the previous instruction may still be in flight
  assign start       = queue_valid && !active_q && (pending_q == '0);
  assign queue_ready = start;

  assign slide_up = req_q.op inside {SLIDE_UP, SLIDE1_UP};
  assign vrf_re_o = active_q;
  assign rd_ok    = vrf_re_o && vrf_rvalid_i;
  assign pop      = vrf_we_o && vrf_wvalid_i;

  // Byte counter, last word and byte enables
  vlen_t               remaining;
  vlen_t               room;
  vlen_t               delta;
  logic                last;
  logic [ByteIdxW-1:0] be_lo;
  vreg_be_t            wbe_d;

  typedef enum logic {
    FIRST_IDLE,
    FIRST_WAIT_WRITE
  } first_state_e;
  first_state_e first_state_q;
  first_state_e first_state_d;

  assign remaining = req_q.vl - counter_q;
  assign room      = vlen_t'(VrfWordBytes) - vlen_t'(counter_q[ByteIdxW-1:0]);
  assign last      = remaining <= room;
  assign delta     = last ? remaining : room;
  assign be_lo     = (first_state_q == FIRST_WAIT_WRITE && req_q.op == SLIDE_UP) ?
                     slide_amount_q[ByteIdxW-1:0] : '0;

  always_comb begin : proc_wbe
    for (int i = 0; i < VrfWordBytes; i++) begin
      wbe_d[i] = (i >= be_lo) && (i < be_lo + delta);
    end
  end

  always_comb begin : proc_first
    first_state_d = first_state_q;
    unique case (first_state_q)
      FIRST_IDLE: begin
        if (start && !op_empty) begin
          first_state_d = FIRST_WAIT_WRITE;
        end
      end
      FIRST_WAIT_WRITE: begin
        if (push) begin
          first_state_d = FIRST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q       <= 1'b0;
      req_q          <= '0;
      slide_amount_q <= '0;
      prefetch_q     <= 1'b0;
      counter_q      <= '0;
      pending_q      <= '0;
      first_state_q  <= FIRST_IDLE;
    end else begin
      first_state_q <= first_state_d;
      pending_q     <= pending_q + 2'(push) - 2'(pop);
      if (start) begin
        active_q       <= !op_empty;
        req_q          <= queue_req;
        slide_amount_q <= amt_start;
        // Slide down always needs the first source word ahead of time
        prefetch_q     <= (queue_req.op inside {SLIDE_DOWN, SLIDE1_DOWN}) ||
                          (amt_start >= vlen_t'(VrfWordBytes));
        counter_q      <= (queue_req.op == SLIDE_UP) ? amt_start : '0;
      end else begin
        if (prefetch_q && rd_ok) begin
          prefetch_q <= 1'b0;
        end
        if (push) begin
          counter_q <= counter_q + delta;
          if (last) begin
            active_q <= 1'b0;
          end
        end
      end
    end
  end

  ////////////////////
  // Addresses
  ////////////////////

  logic signed [SrcW-1:0] cnt_word_s;
  logic signed [SrcW-1:0] amt_word_s;
  logic signed [SrcW-1:0] src_word_s;
  logic                   zero_fill;

  assign cnt_word_s = $signed(SrcW'(counter_q[ByteIdxW +: WordIdxW]));
  assign amt_word_s = $signed(SrcW'(slide_amount_q[$bits(vlen_t)-1:ByteIdxW]));
  assign src_word_s = slide_up ? cnt_word_s - amt_word_s - $signed(SrcW'(prefetch_q))
                               : cnt_word_s + amt_word_s + $signed(SrcW'(!prefetch_q));
  // Source word outside the register reads as zeros
  assign zero_fill  = slide_up ? (src_word_s < 0)
                               : (src_word_s >= $signed(SrcW'(NrWordsPerVector)));

  assign vrf_raddr_o = vreg_addr_t'({req_q.vs2, {WordIdxW{1'b0}}}) +
                       vreg_addr_t'($unsigned(src_word_s));

  ////////////////////
  // Datapath
  ////////////////////

  vreg_data_t wdata_d;
  vrf_wreq_t  wreq_d;
  logic       wreq_valid;

  vsldu_byte_shifter i_byte_shifter (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .step_i       ((prefetch_q && rd_ok) || push),
    .clear_i      (start),
    .slide_up_i   (slide_up),
    .offset_i     (slide_amount_q[ByteIdxW-1:0]),
    .rdata_i      (vrf_rdata_i),
    .zero_fill_i  (zero_fill),
    .insert_up_i  (first_state_q == FIRST_WAIT_WRITE && req_q.op == SLIDE1_UP),
    .insert_down_i(last && req_q.op == SLIDE1_DOWN),
    .insert_pos_i (req_q.vl - slide_amount_q),
    .scalar_i     (req_q.rs1),
    .data_o       (wdata_d)
  );

  // The prefetch read only fills the overflow register
  assign wreq_valid = rd_ok && !prefetch_q;
  assign push       = wreq_valid && wreq_ready;
  assign wreq_d     = '{
    waddr: {req_q.vd, counter_q[ByteIdxW +: WordIdxW]},
    wdata: wdata_d,
    wbe:   wbe_d
  };

  spill_register #(
    .T(vrf_wreq_t)
  ) i_wreq_register (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (wreq_valid),
    .ready_o (wreq_ready),
    .data_i  (wreq_d),
    .valid_o (vrf_we_o),
    .ready_i (vrf_wvalid_i),
    .data_o  (vrf_wreq_o)
  );

  ////////////////////
  // Response
  ////////////////////

  typedef enum logic {
    RSP_RUNNING,
    RSP_WAIT_WVALID
  } rsp_state_e;
  rsp_state_e rsp_state_q;
  rsp_state_e rsp_state_d;

  always_comb begin : proc_rsp
    rsp_state_d = rsp_state_q;
    rsp_valid_o = 1'b0;
    rsp_o       = '0;
    unique case (rsp_state_q)
      RSP_RUNNING: begin
        if (start && op_empty) begin
          rsp_valid_o = 1'b1;
          rsp_o.vd    = queue_req.vd;
        end
        if (push && last) begin
          rsp_state_d = RSP_WAIT_WVALID;
        end
      end
      RSP_WAIT_WVALID: begin
        // Only pops remain here, the last one ends the instruction
        if (pop && pending_q == 2'd1) begin
          rsp_valid_o = 1'b1;
          rsp_o.vd    = req_q.vd;
          rsp_state_d = RSP_RUNNING;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_state_q <= RSP_RUNNING;
    end else begin
      rsp_state_q <= rsp_state_d;
    end
  end

endmodule

/* hdl/vrf.sv */
`timescale 1ns/1ps

module vrf import vsld_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       re_i,
  input  vreg_addr_t raddr_i,
  output vreg_data_t rdata_o,
  output logic       rvalid_o,
  input  logic       we_i,
  input  vrf_wreq_t  wreq_i,
  output logic       wvalid_o,
  input  logic       host_en_i,
  input  logic       host_we_i,
  input  vreg_addr_t host_addr_i,
  input  vreg_data_t host_wdata_i,
  output vreg_data_t host_rdata_o
);

  localparam int unsigned NrWords = NrVregs * NrWordsPerVector;

  vreg_data_t mem_q [NrWords];
  vreg_data_t host_rdata_q;

  // Host owns both ports while it is active
  assign rvalid_o = re_i && !host_en_i;
  assign wvalid_o = we_i && !host_en_i;

  // Read data is combinational
  assign rdata_o = mem_q[raddr_i];

  always_ff @(posedge clk_i) begin
    if (host_en_i) begin
      if (host_we_i) begin
        mem_q[host_addr_i] <= host_wdata_i;
      end
    end else if (we_i) begin
      for (int b = 0; b < VrfWordBytes; b++) begin
        if (wreq_i.wbe[b]) begin
          mem_q[wreq_i.waddr][b*8 +: 8] <= wreq_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Host read data one cycle later
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      host_rdata_q <= '0;
    end else if (host_en_i && !host_we_i) begin
      host_rdata_q <= mem_q[host_addr_i];
    end
  end

  assign host_rdata_o = host_rdata_q;

endmodule

/* hdl/slide_subsys_top.sv */
`timescale 1ns/1ps

module slide_subsys_top import vsld_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  sld_req_t   req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output logic       rsp_valid_o,
  output sld_rsp_t   rsp_o,
  input  logic       host_en_i,
  input  logic       host_we_i,
  input  vreg_addr_t host_addr_i,
  input  vreg_data_t host_wdata_i,
  output vreg_data_t host_rdata_o
);

  // Slide unit to register file
  logic       vrf_re;
  vreg_addr_t vrf_raddr;
  vreg_data_t vrf_rdata;
  logic       vrf_rvalid;
  logic       vrf_we;
  vrf_wreq_t  vrf_wreq;
  logic       vrf_wvalid;

  vsldu i_vsldu (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .vrf_re_o    (vrf_re),
    .vrf_raddr_o (vrf_raddr),
    .vrf_rdata_i (vrf_rdata),
    .vrf_rvalid_i(vrf_rvalid),
    .vrf_we_o    (vrf_we),
    .vrf_wreq_o  (vrf_wreq),
    .vrf_wvalid_i(vrf_wvalid)
  );

  vrf i_vrf (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .re_i        (vrf_re),
    .raddr_i     (vrf_raddr),
    .rdata_o     (vrf_rdata),
    .rvalid_o    (vrf_rvalid),
    .we_i        (vrf_we),
    .wreq_i      (vrf_wreq),
    .wvalid_o    (vrf_wvalid),
    .host_en_i   (host_en_i),
    .host_we_i   (host_we_i),
    .host_addr_i (host_addr_i),
    .host_wdata_i(host_wdata_i),
    .host_rdata_o(host_rdata_o)
  );

endmodule

/* verification/slide_subsys_properties.sv */
`timescale 1ns/1ps

module slide_subsys_properties import vsld_pkg::*; (
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      req_valid_i,
  input logic      req_ready_o,
  input logic      queue_valid,
  input logic      queue_ready,
  input logic      rsp_valid_o,
  input logic      vrf_re_o,
  input logic      vrf_we_o,
  input vrf_wreq_t vrf_wreq_o,
  input logic      vrf_wvalid_i
);

  // Requests held in the queue, counted from its two handshakes
  logic [1:0] queue_count_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      queue_count_q <= '0;
    end else begin
      queue_count_q <= queue_count_q + 2'(req_valid_i && req_ready_o)
                                     - 2'(queue_valid && queue_ready);
    end
  end

  // Nothing toward the register file right after reset
  assert property (@(posedge clk_i) $rose(arst_n_i) |-> !vrf_we_o && !vrf_re_o)
    else $error("register-file strobes active after reset");

  // A second pulse in a row needs another instruction to end right away
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o |=> !rsp_valid_o || queue_ready)
    else $error("rsp_valid_o held longer than one cycle");

  // Held write request must not change
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    vrf_we_o && !vrf_wvalid_i |=> $stable(vrf_wreq_o))
    else $error("write request changed while stalled");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (queue_count_q == 2'd0) |-> req_ready_o && !queue_valid)
    else $error("req_ready_o low with an empty queue");

endmodule

bind vsldu slide_subsys_properties i_properties (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .req_valid_i (req_valid_i),
  .req_ready_o (req_ready_o),
  .queue_valid (queue_valid),
  .queue_ready (queue_ready),
  .rsp_valid_o (rsp_valid_o),
  .vrf_re_o    (vrf_re_o),
  .vrf_we_o    (vrf_we_o),
  .vrf_wreq_o  (vrf_wreq_o),
  .vrf_wvalid_i(vrf_wvalid_i)
);

/* verification/tb_slide_subsys.sv */
`timescale 1ns/1ps

module tb_slide_subsys import vsld_pkg::*; ();

  logic       clk_i;
  logic       arst_n_i;
  sld_req_t   req_i;
  logic       req_valid_i;
  logic       req_ready_o;
  logic       rsp_valid_o;
  sld_rsp_t   rsp_o;
  logic       host_en_i;
  logic       host_we_i;
  vreg_addr_t host_addr_i;
  vreg_data_t host_wdata_i;
  vreg_data_t host_rdata_o;

  // Destination registers of accepted requests, oldest first
  logic [31:0] exp_vd_q[$];
  int          rsp_count;
  int          cycles;
  int          cycle_limit;

  slide_subsys_top DUT (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .host_en_i   (host_en_i),
    .host_we_i   (host_we_i),
    .host_addr_i (host_addr_i),
    .host_wdata_i(host_wdata_i),
    .host_rdata_o(host_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////
  // Monitors
  ////////////////////

  // Responses must follow request order
  always @(posedge clk_i) begin
    if (arst_n_i && rsp_valid_o) begin
      if (exp_vd_q.size() == 0) begin
        $display("A response arrived with no request outstanding at t=%0t", $time);
        $display("TEST FAILED");
        $fatal(1);
      end else begin
        compare("rsp_o.vd", 32'(rsp_o.vd), exp_vd_q.pop_front());
        rsp_count++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("The run took too long and was stopped after %0d cycles", cycles);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  ////////////////////
  // Trace actions
  ////////////////////

  task automatic host_write(input int vreg, input int word, input logic [31:0] value);
    @(negedge clk_i);
    host_en_i    = 1'b1;
    host_we_i    = 1'b1;
    host_addr_i  = vreg_addr_t'(vreg * NrWordsPerVector + word);
    host_wdata_i = value;
    @(negedge clk_i);
    host_en_i = 1'b0;
    host_we_i = 1'b0;
  endtask

  task automatic host_read_check(input int vreg, input int word, input logic [31:0] exp);
    string name;
    name = $sformatf("v%0d word %0d", vreg, word);
    @(negedge clk_i);
    host_en_i   = 1'b1;
    host_we_i   = 1'b0;
    host_addr_i = vreg_addr_t'(vreg * NrWordsPerVector + word);
    @(negedge clk_i);
    host_en_i = 1'b0;
    compare(name, host_rdata_o, exp);
  endtask

  task automatic send_request(input int op, input int vsew, input int vl, input int vd,
                              input int vs2, input logic [31:0] rs1);
    @(negedge clk_i);
    req_i.op    = sld_op_e'(op);
    req_i.vsew  = vsew_e'(vsew);
    req_i.vl    = vlen_t'(vl);
    req_i.vd    = vreg_idx_t'(vd);
    req_i.vs2   = vreg_idx_t'(vs2);
    req_i.rs1   = rs1;
    req_valid_i = 1'b1;
    forever begin
      @(posedge clk_i);
      if (req_ready_o) begin
        break;
      end
    end
    exp_vd_q.push_back(32'(vd));
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // Global timeout covers a response that never comes
  task automatic wait_response(input int count);
    while (rsp_count < count) begin
      @(posedge clk_i);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int          fd;
    int          n;
    int          lines;
    int          waits;
    int          a;
    int          b;
    int          c;
    int          d;
    int          e;
    logic [31:0] value;
    string       kind;
    string       rest;

    req_i        = '0;
    req_valid_i  = 1'b0;
    host_en_i    = 1'b0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    rsp_count    = 0;
    cycles       = 0;
    cycle_limit  = 0;
    waits        = 0;
    arst_n_i     = 1'b0;

    // Limit scales with the trace length
    lines = 0;
    fd = $fopen("verification/slide_trace.txt", "r");
    if (fd == 0) begin
      $display("The trace file could not be opened");
      $display("TEST FAILED");
      $fatal(1);
    end
    while ($fgets(rest, fd) > 0) begin
      lines++;
    end
    $fclose(fd);
    cycle_limit = 200 * lines;

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    compare("req_ready_o", 32'(req_ready_o), 32'd1);
    compare("rsp_valid_o", 32'(rsp_valid_o), 32'd0);

    fd = $fopen("verification/slide_trace.txt", "r");
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind.substr(0, 0) == "#") begin
        n = $fgets(rest, fd);
      end else if (kind == "load") begin
        n = $fscanf(fd, "%d %d %h", a, b, value);
        host_write(a, b, value);
      end else if (kind == "expect") begin
        n = $fscanf(fd, "%d %d %h", a, b, value);
        host_read_check(a, b, value);
      end else if (kind == "request") begin
        n = $fscanf(fd, "%d %d %d %d %d %h", a, b, c, d, e, value);
        send_request(a, b, c, d, e, value);
      end else if (kind == "wait") begin
        waits++;
        wait_response(waits);
      end else begin
        $display("The trace holds an unknown line kind %s", kind);
        $display("TEST FAILED");
        $fatal(1);
      end
    end
    $fclose(fd);

    repeat (4) @(negedge clk_i);
    if (exp_vd_q.size() != 0) begin
      $display("%0d requests never got a response", exp_vd_q.size());
      $display("TEST FAILED");
      $fatal(1);
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

/* verification/slide_trace.txt */
# load/expect: reg word value(hex); request: op(0 up,1 down,2 up1,3 down1) vsew vl vd vs2 rs1(hex)
# wait: next response
load 1 0 13121110
load 1 1 17161514
load 1 2 1b1a1918
load 1 3 1f1e1d1c
load 2 0 a3a2a1a0
load 2 1 a7a6a5a4
load 2 2 abaaa9a8
load 2 3 afaeadac
load 3 0 a3a2a1a0
load 3 1 a7a6a5a4
load 3 2 abaaa9a8
load 3 3 afaeadac
load 4 0 a3a2a1a0
load 4 1 a7a6a5a4
load 4 2 abaaa9a8
load 4 3 afaeadac
load 5 0 a3a2a1a0
load 5 1 a7a6a5a4
load 5 2 abaaa9a8
load 5 3 afaeadac
load 6 0 a3a2a1a0
load 6 1 a7a6a5a4
load 6 2 abaaa9a8
load 6 3 afaeadac
load 7 0 a3a2a1a0
load 7 1 a7a6a5a4
load 7 2 abaaa9a8
load 7 3 afaeadac
# slide up, 8-bit, by 3
request 0 0 16 2 1 00000003
wait
expect 2 0 10a2a1a0
expect 2 1 14131211
expect 2 2 18171615
expect 2 3 1c1b1a19
# slide up, 16-bit, by 3 elements
request 0 1 8 3 1 00000003
wait
expect 3 0 a3a2a1a0
expect 3 1 1110a5a4
expect 3 2 15141312
expect 3 3 19181716
# slide up, 32-bit, by 1 element, vl 3
request 0 2 3 4 1 00000001
wait
expect 4 0 a3a2a1a0
expect 4 1 13121110
expect 4 2 17161514
expect 4 3 afaeadac
# slide down, 8-bit, by 5
request 1 0 16 5 1 00000005
wait
expect 5 0 18171615
expect 5 1 1c1b1a19
expect 5 2 001f1e1d
expect 5 3 00000000
# slide down past the register end
request 1 1 8 6 1 00000014
wait
expect 6 0 00000000
expect 6 1 00000000
expect 6 2 00000000
expect 6 3 00000000
# slide down, 16-bit, vl 3
request 1 1 3 7 1 00000001
wait
expect 7 0 15141312
expect 7 1 a7a61716
expect 7 2 abaaa9a8
expect 7 3 afaeadac
load 2 0 a3a2a1a0
load 2 1 a7a6a5a4
load 2 2 abaaa9a8
load 2 3 afaeadac
load 3 0 a3a2a1a0
load 3 1 a7a6a5a4
load 3 2 abaaa9a8
load 3 3 afaeadac
load 4 0 a3a2a1a0
load 4 1 a7a6a5a4
load 4 2 abaaa9a8
load 4 3 afaeadac
# three slide-one requests back to back with host reads in between
request 2 1 8 2 1 deadbeef
request 3 2 3 3 1 12345678
request 3 0 16 4 1 00000055
expect 1 0 13121110
expect 1 1 17161514
expect 1 2 1b1a1918
expect 1 3 1f1e1d1c
wait
wait
wait
expect 2 0 1110beef
expect 2 1 15141312
expect 2 2 19181716
expect 2 3 1d1c1b1a
expect 3 0 17161514
expect 3 1 1b1a1918
expect 3 2 12345678
expect 3 3 afaeadac
expect 4 0 14131211
expect 4 1 18171615
expect 4 2 1c1b1a19
expect 4 3 551f1e1d

/* sim.f */
common/vsld_pkg.sv
hdl/spill_register.sv
vsldu/vsldu_byte_shifter.sv
vsldu/vsldu.sv
hdl/vrf.sv
hdl/slide_subsys_top.sv
verification/slide_subsys_properties.sv
verification/tb_slide_subsys.sv
